// File: Makefile
VERILATOR ?= verilator
TOP       ?= multdiv_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
src/multdiv_pkg.sv
src/cla_32.sv
src/nr_div.sv
src/booth_mult.sv
src/multdiv.sv
dv/multdiv_checker.sv
dv/multdiv_tb.sv

// File: dv/multdiv_checker.sv
`timescale 1ns/1ns

module multdiv_checker import multdiv_pkg::*; (
    input  logic    clock,
    input  logic    rst,
    input  md_req_t req,
    input  logic    req_valid,
    input  logic    req_ready,
    input  md_rsp_t rsp,
    input  logic    rsp_valid,
    input  logic    rsp_ready,
    output int      err_count,
    output int      rsp_count,
    output int      pending
);

    md_rsp_t exp_q[$];   // expected responses with the oldest first
    int      lat_q[$];   // cycles from accept to rsp_valid
    md_rsp_t held;       // rsp at the last stalled edge
    logic    stalled;
    logic    seen;       // rsp_valid already seen for this request
    int      cyc;        // edges since the last accept

    // expected response from the signed arithmetic rules
    function automatic md_rsp_t ref_model(input md_req_t r);
        md_rsp_t e;
        longint  a;
        longint  b;
        longint  p;
        a = longint'($signed(r.operand_a));
        b = longint'($signed(r.operand_b));
        e.exception = 1'b0;
        if (r.op == OP_MUL) begin
            p           = a * b;   // full 64-bit product
            e.result    = p[31:0];
            e.exception = (p > 64'sd2147483647) || (p < -64'sd2147483648);
        end else if (b == 0) begin
            e.result    = '0;
            e.exception = 1'b1;
        end else if (a == -64'sd2147483648 && b == -64'sd1) begin
            e.result = 32'h8000_0000;   // wraps without an exception
        end else begin
            p        = a / b;   // truncates toward zero
            e.result = p[31:0];
        end
        return e;
    endfunction

    // fixed latency of load, steps, done and capture
    function automatic int expected_latency(input md_req_t r);
        if (r.op == OP_MUL) return MUL_STEPS + 3;
        if (r.operand_b == '0) return 3;   // zero divisor skips the iteration
        return DIV_STEPS + 3;
    endfunction

    always @(posedge clock) begin
        md_rsp_t e;
        if (rst) begin
            exp_q.delete();
            lat_q.delete();
            stalled = 1'b0;
            seen    = 1'b0;
            cyc     = 0;
        end else begin
            cyc = cyc + 1;
            if (rsp_valid && !seen) begin
                seen = 1'b1;
                if (lat_q.size() == 0) begin
                    $display("at %0t: rsp_valid rose with no request outstanding", $time);
                    err_count++;
                end else if (cyc - 1 != lat_q[0]) begin
                    $display("at %0t: response came %0d cycles after its request instead of %0d",
                             $time, cyc - 1, lat_q[0]);
                    err_count++;
                end
            end
            // response must hold under back-pressure
            if (stalled && rsp_valid !== 1'b1) begin
                $display("ERROR at %0t: rsp_valid expected 1, got %b", $time, rsp_valid);
                err_count++;
            end else if (stalled && rsp !== held) begin
                $display("ERROR at %0t: rsp expected %h, got %h", $time, held, rsp);
                err_count++;
            end
            if (rsp_valid && req_ready) begin
                $display("ERROR at %0t: req_ready expected 0, got 1", $time);
                err_count++;
            end
            if (rsp_valid && rsp_ready && exp_q.size() != 0) begin
                e = exp_q.pop_front();
                lat_q.delete(0);
                if (rsp.result !== e.result) begin
                    $display("ERROR at %0t: rsp.result expected %h, got %h",
                             $time, e.result, rsp.result);
                    err_count++;
                end
                if (rsp.exception !== e.exception) begin
                    $display("ERROR at %0t: rsp.exception expected %b, got %b",
                             $time, e.exception, rsp.exception);
                    err_count++;
                end
                rsp_count++;
                seen = 1'b0;
            end
            if (req_valid && req_ready) begin   // request accepted this edge
                exp_q.push_back(ref_model(req));
                lat_q.push_back(expected_latency(req));
                cyc = 0;
            end
            stalled = rsp_valid && !rsp_ready;
            held    = rsp;
        end
        pending = exp_q.size();
    end

endmodule

// File: dv/multdiv_tb.sv
`timescale 1ns/1ns

module multdiv_tb import multdiv_pkg::*; ();

    localparam int N_DIV_RAND = 200;
    localparam int N_MUL_RAND = 100;
    localparam int N_BP       = 30;
    localparam int N_B2B      = 40;
    localparam int N_FIXED    = 30;   // hand-picked operands rounded up
    localparam int MAX_STALL  = 12;
    // up to 40 cycles per request with idle gaps, plus stalls and reset
    localparam int TIMEOUT_CYCLES = 40 * (N_DIV_RAND + N_MUL_RAND + N_BP + N_B2B + N_FIXED)
                                  + N_BP * MAX_STALL + 100;

    logic    clock;
    logic    rst;
    md_req_t req;
    logic    req_valid;
    logic    req_ready;
    md_rsp_t rsp;
    logic    rsp_valid;
    logic    rsp_ready;
    int      err_count;
    int      rsp_count;
    int      pending;
    int      cycles = 0;
    int      tb_errors = 0;   // lost, duplicated or reset-state problems
    int      tests_run = 0;
    md_req_t req_list[$];     // requests of the current test

    multdiv dut0 (
        .clock(clock), .rst(rst), .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
    );

    multdiv_checker chk0 (
        .clock(clock), .rst(rst), .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .err_count(err_count), .rsp_count(rsp_count), .pending(pending)
    );

    always #20 clock = ~clock;   // 40 ns period

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out waiting for a response after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic md_req_t make_req(input md_op_t op, input logic [31:0] a,
                                         input logic [31:0] b);
        md_req_t r;
        r.op        = op;
        r.operand_a = a;
        r.operand_b = b;
        return r;
    endfunction

    // full range or sign-extended small values so products both fit and overflow
    function automatic logic [31:0] rand_operand();
        logic [31:0] v;
        v = $urandom();
        case ($urandom_range(2, 0))
            0: v = {{24{v[31]}}, v[7:0]};
            1: v = {{16{v[31]}}, v[15:0]};
            default: v = v;
        endcase
        return v;
    endfunction

    task automatic send_all(input int max_gap);
        foreach (req_list[i]) begin
            repeat ($urandom_range(max_gap, 0)) begin
                @(posedge clock);
                #2;
            end
            req       = req_list[i];
            req_valid = 1'b1;
            while (!req_ready) begin   // busy until the last response is taken
                @(posedge clock);
                #2;
            end
            @(posedge clock);   // transfer edge
            #2;
            req_valid = 1'b0;
        end
    endtask

    task automatic collect_rsps(input int n, input int max_stall);
        for (int k = 0; k < n; k++) begin
            while (!rsp_valid) begin
                @(posedge clock);
                #2;
            end
            repeat ($urandom_range(max_stall, 0)) begin   // back-pressure stretch
                @(posedge clock);
                #2;
            end
            rsp_ready = 1'b1;
            @(posedge clock);
            #2;
            rsp_ready = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int max_gap, input int max_stall);
        int errs;
        int tb_errs;
        int rsps;
        int n;
        errs    = err_count;
        tb_errs = tb_errors;
        rsps    = rsp_count;
        n       = req_list.size();
        fork
            send_all(max_gap);
            collect_rsps(n, max_stall);
        join
        if (rsp_count - rsps != n || pending != 0) begin
            $display("%s: %0d requests sent but %0d responses checked, %0d still outstanding",
                     name, n, rsp_count - rsps, pending);
            tb_errors++;
        end
        $display("%s: %0d requests, %0d errors", name, n,
                 err_count - errs + tb_errors - tb_errs);
        tests_run++;
        req_list.delete();
    endtask

    initial begin
        logic [31:0] b;
        void'($urandom(86));
        clock     = 1'b0;
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        repeat (2) @(posedge clock);
        #2;
        rst = 1'b0;
        if (req_ready !== 1'b1 || rsp_valid !== 1'b0) begin
            $display("after reset the unit is not idle with req_ready high and rsp_valid low");
            tb_errors++;
        end

        // all four sign combinations plus the extreme operands
        req_list.push_back(make_req(OP_DIV, 32'd100, 32'd7));
        req_list.push_back(make_req(OP_DIV, -32'sd100, 32'd7));
        req_list.push_back(make_req(OP_DIV, 32'd100, -32'sd7));
        req_list.push_back(make_req(OP_DIV, -32'sd100, -32'sd7));
        req_list.push_back(make_req(OP_DIV, 32'd7, 32'd100));
        req_list.push_back(make_req(OP_DIV, 32'h8000_0000, -32'sd1));
        req_list.push_back(make_req(OP_DIV, 32'h8000_0000, 32'h8000_0000));
        req_list.push_back(make_req(OP_DIV, 32'h7fff_ffff, 32'h8000_0000));
        req_list.push_back(make_req(OP_DIV, 32'h8000_0000, 32'd3));
        for (int i = 0; i < N_DIV_RAND; i++) begin
            b = rand_operand();
            req_list.push_back(make_req(OP_DIV, rand_operand(), (b == '0) ? 32'd5 : b));
        end
        run_test("signed_divide", 2, 0);

        req_list.push_back(make_req(OP_DIV, 32'd0, 32'd0));
        req_list.push_back(make_req(OP_DIV, 32'h7fff_ffff, 32'd0));
        req_list.push_back(make_req(OP_DIV, 32'h8000_0000, 32'd0));
        for (int i = 0; i < 3; i++) begin
            req_list.push_back(make_req(OP_DIV, rand_operand(), 32'd0));
        end
        run_test("divide_by_zero", 2, 0);

        req_list.push_back(make_req(OP_MUL, 32'd3, 32'd5));
        req_list.push_back(make_req(OP_MUL, -32'sd3, 32'd5));
        req_list.push_back(make_req(OP_MUL, -32'sd3, -32'sd5));
        req_list.push_back(make_req(OP_MUL, 32'h8000_0000, 32'd1));
        req_list.push_back(make_req(OP_MUL, 32'h8000_0000, -32'sd1));   // +2^31 overflows
        req_list.push_back(make_req(OP_MUL, 32'h8000_0000, 32'h8000_0000));
        req_list.push_back(make_req(OP_MUL, 32'h0001_0000, -32'sd32768));   // exactly -2^31
        req_list.push_back(make_req(OP_MUL, 32'h0001_0000, 32'd32768));
        for (int i = 0; i < N_MUL_RAND; i++) begin
            req_list.push_back(make_req(OP_MUL, rand_operand(), rand_operand()));
        end
        run_test("signed_multiply", 2, 0);

        for (int i = 0; i < N_BP; i++) begin
            req_list.push_back(make_req(md_op_t'($urandom_range(1, 0)), rand_operand(),
                                        rand_operand()));
        end
        run_test("back_pressure", 2, MAX_STALL);

        for (int i = 0; i < N_B2B; i++) begin
            req_list.push_back(make_req((i % 2) ? OP_DIV : OP_MUL, rand_operand(),
                                        rand_operand()));
        end
        run_test("back_to_back", 0, 0);

        $display("%0d tests, %0d responses checked, %0d errors", tests_run, rsp_count,
                 err_count + tb_errors);
        if (err_count + tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src/booth_mult.sv
`timescale 1ns/1ns

module booth_mult import multdiv_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              start,
    input  logic [WORD_W-1:0] multiplicand,
    input  logic [WORD_W-1:0] multiplier,
    output logic              done,
    output logic              exception,
    output logic [WORD_W-1:0] product
);

    unit_state_t          state_q;
    logic [MUL_CNT_W-1:0] cnt_q;

    // {upper, lower, previous bit}
    logic [2*WORD_W:0] work_q;
    logic [WORD_W-1:0] mcand_q;

    logic [WORD_W-1:0] hi;
    logic [WORD_W-1:0] lo;
    logic              prev;
    logic              sub;
    logic              skip;
    logic [WORD_W-1:0] addend;
    logic [WORD_W-1:0] sum;
    logic              sum_ovf;
    logic [WORD_W-1:0] hi_next;
    logic              sign_next;
    logic              accept;

    assign hi   = work_q[2*WORD_W:WORD_W+1];
    assign lo   = work_q[WORD_W:1];
    assign prev = work_q[0];

    // booth pair: 10 -> subtract, 01 -> add, 00/11 -> skip
    assign sub  = lo[0] & ~prev;
    assign skip = ~(lo[0] ^ prev);

    assign addend = sub ? ~mcand_q : mcand_q;

    cla_32 hi_addsub (
        .a(hi), .b(addend), .cin(sub),
        .sum(sum), .cout(), .signed_ovf(sum_ovf)
    );

    // true 33-bit sign survives the shift even when the sum wraps
    assign hi_next   = skip ? hi : sum;
    assign sign_next = skip ? hi[WORD_W-1] : (sum[WORD_W-1] ^ sum_ovf);

    assign accept = start && (state_q == ST_IDLE);

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            done    <= 1'b0;
        end else begin
            done <= (state_q == ST_DONE);
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_RUN;
                        cnt_q   <= MUL_CNT_W'(MUL_STEPS);
                    end
                end
                ST_RUN: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == MUL_CNT_W'(1)) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            mcand_q <= multiplicand;
            work_q  <= {{WORD_W{1'b0}}, multiplier, 1'b0};
        end else if (state_q == ST_RUN) begin
            work_q <= {sign_next, hi_next, lo};   // add/sub then arith shift right
        end
    end

    // product fits when the upper word is all sign copies of the lower word
    always_ff @(posedge clock) begin
        if (state_q == ST_DONE) begin
            product   <= lo;
            exception <= (hi != {WORD_W{lo[WORD_W-1]}});
        end
    end

    a_done_pulse: assert property (@(posedge clock) disable iff (rst)
        done |=> !done);

endmodule

// File: src/cla_32.sv
`timescale 1ns/1ns

module cla_32 (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic        cin,
    output logic [31:0] sum,
    output logic        cout,
    output logic        signed_ovf
);

    logic [31:0] g;          // bit generate
    logic [31:0] p;          // bit propagate
    logic [3:0]  grp_g;      // 8-bit group generate
    logic [3:0]  grp_p;      // 8-bit group propagate
    logic [4:0]  grp_c;      // carry into each group, [4] is carry out
    logic [32:0] c;

    assign g = a & b;
    assign p = a ^ b;

    // first level, group g/p folded up from bit 0 of each byte
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            grp_g[k] = g[8*k];
            grp_p[k] = p[8*k];
            for (int i = 1; i < 8; i++) begin
                grp_g[k] = g[8*k+i] | (p[8*k+i] & grp_g[k]);
                grp_p[k] = grp_p[k] & p[8*k+i];
            end
        end
    end

    // second level lookahead across the four groups
    assign grp_c[0] = cin;
    assign grp_c[1] = grp_g[0] | (grp_p[0] & cin);
    assign grp_c[2] = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & cin);
    assign grp_c[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0])
                    | (grp_p[2] & grp_p[1] & grp_p[0] & cin);
    assign grp_c[4] = grp_g[3] | (grp_p[3] & grp_c[3]);

    // bit carries inside each group start from the group carry-in
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            c[8*k] = grp_c[k];
            for (int i = 0; i < 7; i++) begin
                c[8*k+i+1] = g[8*k+i] | (p[8*k+i] & c[8*k+i]);
            end
        end
        c[32] = grp_c[4];
    end

    assign sum        = p ^ c[31:0];
    assign cout       = c[32];
    assign signed_ovf = c[31] ^ c[32];   // carry into msb differs from carry out

endmodule

// File: src/multdiv.sv
`timescale 1ns/1ns

module multdiv import multdiv_pkg::*; (
    input  logic    clock,
    input  logic    rst,
    input  md_req_t req,
    input  logic    req_valid,
    output logic    req_ready,
    output md_rsp_t rsp,
    output logic    rsp_valid,
    input  logic    rsp_ready
);

    unit_state_t state_q;
    md_req_t     req_q;        // operands held for the running datapath
    md_rsp_t     rsp_q;
    logic        div_start_q;
    logic        mul_start_q;
    logic        accept;

    logic              div_done;
    logic              div_exc;
    logic [WORD_W-1:0] div_quot;
    logic              mul_done;
    logic              mul_exc;
    logic [WORD_W-1:0] mul_prod;
    logic              unit_done;

    assign req_ready = (state_q == ST_IDLE);   // one op in flight
    assign accept    = req_valid && req_ready;
    assign rsp_valid = (state_q == ST_DONE);
    assign rsp       = rsp_q;
    assign unit_done = div_done || mul_done;

    nr_div div0 (
        .clock(clock), .rst(rst), .start(div_start_q),
        .dividend(req_q.operand_a), .divisor(req_q.operand_b),
        .done(div_done), .exception(div_exc), .quotient(div_quot)
    );

    booth_mult mul0 (
        .clock(clock), .rst(rst), .start(mul_start_q),
        .multiplicand(req_q.operand_a), .multiplier(req_q.operand_b),
        .done(mul_done), .exception(mul_exc), .product(mul_prod)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            div_start_q <= 1'b0;
            mul_start_q <= 1'b0;
        end else begin
            // one-cycle start to the unit picked by op
            div_start_q <= accept && (req.op == OP_DIV);
            mul_start_q <= accept && (req.op == OP_MUL);
            case (state_q)
                ST_IDLE: if (accept) state_q <= ST_RUN;
                ST_RUN:  if (unit_done) state_q <= ST_DONE;
                ST_DONE: if (rsp_ready) state_q <= ST_IDLE;   // hold under back-pressure
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= req;
        end
        if ((state_q == ST_RUN) && unit_done) begin
            rsp_q.result    <= (req_q.op == OP_DIV) ? div_quot : mul_prod;
            rsp_q.exception <= (req_q.op == OP_DIV) ? div_exc : mul_exc;
        end
    end

    a_rsp_hold: assert property (@(posedge clock) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)));

    // datapath done only comes back for an op we started
    a_done_in_run: assert property (@(posedge clock) disable iff (rst)
        unit_done |-> (state_q == ST_RUN));

endmodule

// File: src/multdiv_pkg.sv
package multdiv_pkg;

    localparam int WORD_W    = 32;
    localparam int DIV_STEPS = 33;   // leading step plus one per quotient bit
    localparam int MUL_STEPS = 32;   // one booth step per multiplier bit

    // step counters, wide enough to hold the full count
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);
    localparam int MUL_CNT_W = $clog2(MUL_STEPS + 1);

    typedef enum logic {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } md_op_t;

    // shared by both datapaths and the top controller
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2   // one cycle in the datapaths, held in the top
    } unit_state_t;

    typedef struct packed {
        md_op_t            op;
        logic [WORD_W-1:0] operand_a;   // dividend or multiplicand
        logic [WORD_W-1:0] operand_b;   // divisor or multiplier
    } md_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] result;      // quotient or low product word
        logic              exception;   // div by zero or product overflow
    } md_rsp_t;

endpackage

// File: src/nr_div.sv
`timescale 1ns/1ns

module nr_div import multdiv_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              start,
    input  logic [WORD_W-1:0] dividend,
    input  logic [WORD_W-1:0] divisor,
    output logic              done,
    output logic              exception,
    output logic [WORD_W-1:0] quotient
);

    unit_state_t          state_q;
    logic [DIV_CNT_W-1:0] cnt_q;       // steps left

    logic [WORD_W-1:0] q_q;            // dividend out the top, quotient bits in the bottom
    logic [WORD_W-1:0] m_q;            // |divisor|
    logic [WORD_W-1:0] a_q;            // partial remainder, shifted
    logic              neg_q;          // result sign
    logic              sum_neg_q;      // last remainder was negative -> add next

    logic [WORD_W-1:0] dividend_neg;
    logic [WORD_W-1:0] divisor_neg;
    logic [WORD_W-1:0] abs_dividend;
    logic [WORD_W-1:0] abs_divisor;
    logic [WORD_W-1:0] addend;
    logic [WORD_W-1:0] sum;
    logic [WORD_W-1:0] q_neg;
    logic              accept;
    logic              div_zero;

    // two's complement negations, ~x + 1
    cla_32 dividend_cmp (
        .a(~dividend), .b('0), .cin(1'b1),
        .sum(dividend_neg), .cout(), .signed_ovf()
    );

    cla_32 divisor_cmp (
        .a(~divisor), .b('0), .cin(1'b1),
        .sum(divisor_neg), .cout(), .signed_ovf()
    );

    assign abs_dividend = dividend[WORD_W-1] ? dividend_neg : dividend;
    assign abs_divisor  = divisor[WORD_W-1] ? divisor_neg : divisor;

    assign accept = start && (state_q == ST_IDLE);   // start while busy is dropped

    // subtract while the remainder is non-negative, add it back otherwise
    // sign comes from a flag since the shifted remainder can wrap bit 31
    assign addend = sum_neg_q ? m_q : ~m_q;

    cla_32 acc_addsub (
        .a(a_q), .b(addend), .cin(~sum_neg_q),
        .sum(sum), .cout(), .signed_ovf()
    );

    cla_32 result_cmp (
        .a(~q_q), .b('0), .cin(1'b1),
        .sum(q_neg), .cout(), .signed_ovf()
    );

    assign div_zero = ~|m_q;   // abs of zero is zero

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            done    <= 1'b0;
        end else begin
            done <= (state_q == ST_DONE);   // done state is one cycle
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        if (~|divisor) begin
                            state_q <= ST_DONE;   // no iteration for zero divisor
                        end else begin
                            state_q <= ST_RUN;
                            cnt_q   <= DIV_CNT_W'(DIV_STEPS);
                        end
                    end
                end
                ST_RUN: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == DIV_CNT_W'(1)) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clock) begin
        if (accept) begin
            q_q       <= abs_dividend;
            m_q       <= abs_divisor;
            a_q       <= '0;
            neg_q     <= dividend[WORD_W-1] ^ divisor[WORD_W-1];
            sum_neg_q <= 1'b0;   // first step always subtracts
        end else if (state_q == ST_RUN) begin
            a_q       <= {sum[WORD_W-2:0], q_q[WORD_W-1]};
            q_q       <= {q_q[WORD_W-2:0], ~sum[WORD_W-1]};
            sum_neg_q <= sum[WORD_W-1];
        end
    end

    // sign fix on the way out, zero divisor forces 0
    always_ff @(posedge clock) begin
        if (state_q == ST_DONE) begin
            quotient  <= div_zero ? '0 : (neg_q ? q_neg : q_q);
            exception <= div_zero;
        end
    end

    // top must wait for done before the next start
    a_no_start_busy: assert property (@(posedge clock) disable iff (rst)
        (cnt_q != '0) |-> !start);

    a_done_pulse: assert property (@(posedge clock) disable iff (rst)
        done |=> !done);

endmodule
